// ==== Bender.yml ====
package:
  name: gf128_mult

sources:
  - gf_mult_pkg.sv
  - gf_prod_if.sv
  - gf_xor_tree.sv
  - gf_clmul64.sv
  - gf_karatsuba128.sv
  - gf_reduce128.sv
  - gf128_mult_top.sv
  - target: test
    files:
      - tb_gf128_mult.sv

// ==== gf128_mult_top.sv ====
`default_nettype none

module gf128_mult_top
(
    input  logic                               i_clock,
    input  logic                               i_rst_n,
    input  logic                               i_valid,
    input  logic [gf_mult_pkg::GF_NB_WORD-1:0] i_a,
    input  logic [gf_mult_pkg::GF_NB_WORD-1:0] i_b,
    input  logic [gf_mult_pkg::GF_NB_TAG-1:0]  i_tag,
    output logic                               o_valid,
    output logic [gf_mult_pkg::GF_NB_WORD-1:0] o_z,
    output logic [gf_mult_pkg::GF_NB_TAG-1:0]  o_tag
);

    // Unreduced product between the two stages.
    gf_prod_if u_prod_bus ();

    // Full carry-less product, three cycles.
    gf_karatsuba128 u_karatsuba
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_tag   (i_tag),
        .o_prod  (u_prod_bus)
    );

    // Modular fold, one cycle.
    gf_reduce128 u_reduce
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_prod  (u_prod_bus),
        .o_valid (o_valid),
        .o_z     (o_z),
        .o_tag   (o_tag)
    );

endmodule

`default_nettype wire

// ==== gf_clmul64.sv ====
`default_nettype none

module gf_clmul64
(
    input  logic                                i_clock,
    input  logic                                i_rst_n,
    input  logic                                i_valid,
    input  logic [gf_mult_pkg::GF_NB_HALF-1:0]  i_x,
    input  logic [gf_mult_pkg::GF_NB_HALF-1:0]  i_y,
    output logic                                o_valid,
    output logic [gf_mult_pkg::GF_NB_HPROD-1:0] o_z
);

    import gf_mult_pkg::*;

    // All partial products side by side, term k at slice k.
    logic [GF_NB_HALF*GF_NB_HPROD-1:0] terms;

    // Term k is i_y times x^k when bit k of i_x is set.
    for (genvar k = 0; k < GF_NB_HALF; k++)
    begin : g_pprod
        assign terms[k*GF_NB_HPROD +: GF_NB_HPROD]
            = ({GF_NB_HPROD{i_x[k]}} & GF_NB_HPROD'(i_y)) << k;
    end

    // Carry-less sum of the partial products.
    gf_xor_tree
    #(
        .N_TERMS (GF_NB_HALF),
        .NB_TERM (GF_NB_HPROD)
    )
    u_xor_tree
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_terms (terms),
        .o_valid (o_valid),
        .o_sum   (o_z)
    );

    // Tree depth must give the fixed multiplier latency.
    a_clmul_latency: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_valid |-> ##GF_CLMUL_LAT o_valid
    );

endmodule

`default_nettype wire

// ==== gf_karatsuba128.sv ====
`default_nettype none

module gf_karatsuba128
(
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_valid,
    input  gf_mult_pkg::gf_word_u             i_a,
    input  gf_mult_pkg::gf_word_u             i_b,
    input  logic [gf_mult_pkg::GF_NB_TAG-1:0] i_tag,
    gf_prod_if.src                            o_prod
);

    import gf_mult_pkg::*;

    // Tag delay covers the multipliers plus recombination.
    localparam int TAG_DEPTH = GF_CLMUL_LAT + 1;

    // Cross operands, hi XOR lo.
    logic [GF_NB_HALF-1:0]  a_mid;
    logic [GF_NB_HALF-1:0]  b_mid;

    // Half products and their valids.
    logic [GF_NB_HPROD-1:0] p_hh;
    logic [GF_NB_HPROD-1:0] p_ll;
    logic [GF_NB_HPROD-1:0] p_mm;
    logic                   v_hh;
    logic                   v_ll;
    logic                   v_mm;

    // Middle term and full unreduced product.
    logic [GF_NB_HPROD-1:0] mid;
    logic [GF_NB_PROD-1:0]  prod;

    logic [GF_NB_TAG-1:0]   tag_pipe [TAG_DEPTH];

    assign a_mid = i_a.half.hi ^ i_a.half.lo;
    assign b_mid = i_b.half.hi ^ i_b.half.lo;

    // High halves.
    gf_clmul64 u_clmul_hh
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_x     (i_a.half.hi),
        .i_y     (i_b.half.hi),
        .o_valid (v_hh),
        .o_z     (p_hh)
    );

    // Low halves.
    gf_clmul64 u_clmul_ll
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_x     (i_a.half.lo),
        .i_y     (i_b.half.lo),
        .o_valid (v_ll),
        .o_z     (p_ll)
    );

    // Cross product.
    gf_clmul64 u_clmul_mm
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_x     (a_mid),
        .i_y     (b_mid),
        .o_valid (v_mm),
        .o_z     (p_mm)
    );

    // Karatsuba middle term.
    assign mid  = p_mm ^ p_hh ^ p_ll;
    // hh at x^128, ll at x^0, middle at x^64.
    assign prod = {p_hh, 1'b0, p_ll} ^ {{GF_NB_HALF{1'b0}}, mid, {GF_NB_HALF{1'b0}}};

    // Recombination register.
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_prod.valid   <= 1'b0;
            o_prod.prod_hi <= '0;
            o_prod.prod_lo <= '0;
        end
        else
        begin
            o_prod.valid <= v_hh;
            if (v_hh)
            begin
                o_prod.prod_hi <= prod[GF_NB_PROD-1:GF_NB_HPROD];
                o_prod.prod_lo <= prod[GF_NB_HPROD-1:0];
            end
        end
    end

    // Tag shift register.
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < TAG_DEPTH; i++)
            begin
                tag_pipe[i] <= '0;
            end
        end
        else
        begin
            tag_pipe[0] <= i_tag;
            for (int i = 1; i < TAG_DEPTH; i++)
            begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign o_prod.tag = tag_pipe[TAG_DEPTH-1];

    // The three multipliers run in lock step.
    a_mult_in_step: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (v_hh == v_ll) && (v_ll == v_mm)
    );

endmodule

`default_nettype wire

// ==== gf_mult_pkg.sv ====
`default_nettype none

package gf_mult_pkg;

    // Field element and half-operand widths.
    localparam int GF_NB_WORD  = 128;
    localparam int GF_NB_HALF  = GF_NB_WORD / 2;

    // Carry-less products have one bit less than twice the operand.
    localparam int GF_NB_HPROD = 2 * GF_NB_HALF - 1;
    localparam int GF_NB_PROD  = 2 * GF_NB_WORD - 1;

    // Request tag carried alongside each operand pair.
    localparam int GF_NB_TAG   = 4;

    // Low terms of x^128 + x^7 + x^2 + x + 1.
    localparam logic [7:0] GF_POLY_LOW = 8'h87;

    // XOR tree levels between register banks.
    localparam int GF_LEVELS_PER_REG = 3;

    // Pipeline depths in clock cycles.
    localparam int GF_CLMUL_LAT = 2;
    localparam int GF_TOTAL_LAT = 4;

    // Split view used by the Karatsuba stage.
    typedef struct packed {
        logic [GF_NB_HALF-1:0] hi;
        logic [GF_NB_HALF-1:0] lo;
    } gf_half_t;

    // One field element, read whole or as two halves.
    typedef union packed {
        logic [GF_NB_WORD-1:0] word;
        gf_half_t              half;
    } gf_word_u;

endpackage

`default_nettype wire

// ==== gf_prod_if.sv ====
`default_nettype none

interface gf_prod_if;

    import gf_mult_pkg::*;

    // Single-cycle strobe per product.
    logic                   valid;
    // Request tag, aligned with valid.
    logic [GF_NB_TAG-1:0]   tag;
    // Coefficients x^127 through x^254.
    logic [GF_NB_WORD-1:0]  prod_hi;
    // Coefficients x^0 through x^126.
    logic [GF_NB_HPROD-1:0] prod_lo;

    // Karatsuba side.
    modport src (output valid, output tag, output prod_hi, output prod_lo);

    // Reducer side.
    modport dst (input valid, input tag, input prod_hi, input prod_lo);

endinterface

`default_nettype wire

// ==== gf_reduce128.sv ====
`default_nettype none

module gf_reduce128
(
    input  logic                               i_clock,
    input  logic                               i_rst_n,
    gf_prod_if.dst                             i_prod,
    output logic                               o_valid,
    output logic [gf_mult_pkg::GF_NB_WORD-1:0] o_z,
    output logic [gf_mult_pkg::GF_NB_TAG-1:0]  o_tag
);

    import gf_mult_pkg::*;

    // Degree of the low polynomial terms.
    localparam int NB_POLY  = $bits(GF_POLY_LOW);
    // First fold, the high part times the low terms.
    localparam int NB_FOLD1 = GF_NB_HPROD + NB_POLY - 1;
    // Spill above x^127 after the first fold.
    localparam int NB_CARRY = NB_FOLD1 - GF_NB_WORD;
    localparam int NB_FOLD2 = NB_CARRY + NB_POLY - 1;

    // x^0..x^127 and x^128..x^254 of the product.
    logic [GF_NB_WORD-1:0]  low;
    logic [GF_NB_HPROD-1:0] high;

    logic [NB_FOLD1-1:0]    fold1;
    logic [NB_CARRY-1:0]    carry;
    logic [NB_FOLD2-1:0]    fold2;
    logic [GF_NB_WORD-1:0]  z_next;

    // Bit 127 sits at the bottom of prod_hi.
    assign low  = {i_prod.prod_hi[0], i_prod.prod_lo};
    assign high = i_prod.prod_hi[GF_NB_WORD-1:1];

    // x^128 folds to x^7 + x^2 + x + 1.
    always_comb
    begin
        fold1 = '0;
        for (int k = 0; k < NB_POLY; k++)
        begin
            if (GF_POLY_LOW[k])
            begin
                fold1 = fold1 ^ (NB_FOLD1'(high) << k);
            end
        end
    end

    assign carry = fold1[NB_FOLD1-1:GF_NB_WORD];

    // Second fold of the few spilled bits.
    always_comb
    begin
        fold2 = '0;
        for (int k = 0; k < NB_POLY; k++)
        begin
            if (GF_POLY_LOW[k])
            begin
                fold2 = fold2 ^ (NB_FOLD2'(carry) << k);
            end
        end
    end

    assign z_next = low ^ fold1[GF_NB_WORD-1:0] ^ GF_NB_WORD'(fold2);

    // Output register.
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
            o_z     <= '0;
            o_tag   <= '0;
        end
        else
        begin
            o_valid <= i_prod.valid;
            if (i_prod.valid)
            begin
                o_z   <= z_next;
                o_tag <= i_prod.tag;
            end
        end
    end

    // One cycle through the reducer.
    a_reduce_latency: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_valid == $past(i_prod.valid)
    );

endmodule

`default_nettype wire

// ==== gf_xor_tree.sv ====
`default_nettype none

module gf_xor_tree
#(
    parameter int N_TERMS = 64,
    parameter int NB_TERM = 127
)
(
    input  logic                       i_clock,
    input  logic                       i_rst_n,
    input  logic                       i_valid,
    input  logic [N_TERMS*NB_TERM-1:0] i_terms,
    output logic                       o_valid,
    output logic [NB_TERM-1:0]         o_sum
);

    import gf_mult_pkg::*;

    // Tree depth and padded leaf count.
    localparam int N_LEVELS = $clog2(N_TERMS);
    localparam int N_PAD    = 1 << N_LEVELS;

    // Node values per level, level 0 holds the leaves.
    wire [NB_TERM-1:0] node [N_LEVELS+1][N_PAD];
    // Valid that travels with each level.
    wire [N_LEVELS:0]  vld;

    assign vld[0] = i_valid;

    // Leaves, padded with zero terms up to a power of two.
    for (genvar j = 0; j < N_PAD; j++)
    begin : g_leaf
        if (j < N_TERMS)
        begin : g_term
            assign node[0][j] = i_terms[j*NB_TERM +: NB_TERM];
        end
        else
        begin : g_zero
            assign node[0][j] = '0;
        end
    end

    // Pairwise XOR, one level per iteration.
    for (genvar lvl = 1; lvl <= N_LEVELS; lvl++)
    begin : g_level
        localparam int N_NODE  = N_PAD >> lvl;
        // Register every few levels, and always after the root.
        localparam bit REG_LVL = ((lvl % GF_LEVELS_PER_REG) == 0) || (lvl == N_LEVELS);

        if (REG_LVL)
        begin : g_reg
            logic [NB_TERM-1:0] sum_q [N_NODE];
            logic               vld_q;

            always_ff @(posedge i_clock or negedge i_rst_n)
            begin
                if (!i_rst_n)
                begin
                    vld_q <= 1'b0;
                    for (int j = 0; j < N_NODE; j++)
                    begin
                        sum_q[j] <= '0;
                    end
                end
                else
                begin
                    vld_q <= vld[lvl-1];
                    // Data only moves with a valid word.
                    if (vld[lvl-1])
                    begin
                        for (int j = 0; j < N_NODE; j++)
                        begin
                            sum_q[j] <= node[lvl-1][2*j] ^ node[lvl-1][2*j+1];
                        end
                    end
                end
            end

            assign vld[lvl] = vld_q;
            for (genvar j = 0; j < N_NODE; j++)
            begin : g_out
                assign node[lvl][j] = sum_q[j];
            end
        end
        else
        begin : g_comb
            // Plain XOR level, no storage.
            assign vld[lvl] = vld[lvl-1];
            for (genvar j = 0; j < N_NODE; j++)
            begin : g_xor
                assign node[lvl][j] = node[lvl-1][2*j] ^ node[lvl-1][2*j+1];
            end
        end
    end

    // Root of the tree.
    assign o_sum   = node[N_LEVELS][0];
    assign o_valid = vld[N_LEVELS];

    // Output strobe is always resolved once out of reset.
    a_valid_known: assert property (
        @(posedge i_clock) disable iff (!i_rst_n) !$isunknown(o_valid)
    );

endmodule

`default_nettype wire

// ==== list.f ====
gf_mult_pkg.sv
gf_prod_if.sv
gf_xor_tree.sv
gf_clmul64.sv
gf_karatsuba128.sv
gf_reduce128.sv
gf128_mult_top.sv
tb_gf128_mult.sv

// ==== tb_gf128_mult.sv ====
`default_nettype none

module tb_gf128_mult;

    timeunit 1ns;
    timeprecision 1ps;

    // DUT ports.
    logic         i_clock;
    logic         i_rst_n;
    logic         i_valid;
    logic [127:0] i_a;
    logic [127:0] i_b;
    logic [3:0]   i_tag;
    logic         o_valid;
    logic [127:0] o_z;
    logic [3:0]   o_tag;

    // Random source and run state.
    integer      seed = 32'h6e27e1c9;
    string       test_name;
    int          n_results = 0;
    int unsigned cyc = 0;

    // Pending results, oldest first.
    logic [127:0] exp_z [$];
    logic [3:0]   exp_tag [$];
    int unsigned  exp_cyc [$];

    // Length of the longest run of results on consecutive cycles.
    int unsigned last_out_cyc = 0;
    int          run_len = 0;
    int          max_run = 0;

    gf128_mult_top uut
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_tag   (i_tag),
        .o_valid (o_valid),
        .o_z     (o_z),
        .o_tag   (o_tag)
    );

    initial i_clock = 1'b0;
    always #10 i_clock = ~i_clock;

    always @(posedge i_clock) cyc <= cyc + 1;

    // Schoolbook carry-less product, then long division by the field polynomial.
    function automatic logic [127:0] mult_model(input logic [127:0] x, input logic [127:0] y);
        logic [254:0] p;
        p = '0;
        for (int i = 0; i < 128; i++)
        begin
            if (x[i])
            begin
                p = p ^ (255'(y) << i);
            end
        end
        // Clear x^i and add x^(i-128) * (x^7+x^2+x+1).
        for (int i = 254; i >= 128; i--)
        begin
            if (p[i])
            begin
                p = p ^ (255'h87 << (i - 128)) ^ (255'b1 << i);
            end
        end
        return p[127:0];
    endfunction

    function automatic logic [127:0] rand128();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic value_error(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        $display("CHECK FAILED test=%s %s expected=%h actual=%h",
                 test_name, what, expected, actual);
        abort_run();
    endtask

    task automatic protocol_error(input string what);
        $display("ERROR in test %s: %s", test_name, what);
        abort_run();
    endtask

    // One operand pair, launched just after the clock edge.
    task automatic drive_pair(input logic [127:0] a, input logic [127:0] b,
                              input logic [3:0] tag);
        @(posedge i_clock);
        #2;
        i_valid = 1'b1;
        i_a     = a;
        i_b     = b;
        i_tag   = tag;
    endtask

    // Idle cycle with junk operands, which must not leak out.
    task automatic drive_idle();
        @(posedge i_clock);
        #2;
        i_valid = 1'b0;
        i_a     = rand128();
        i_b     = rand128();
        i_tag   = 4'($random(seed));
    endtask

    // Poll until every pending result is out.
    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_z.size() != 0)
        begin
            if (waited >= limit)
            begin
                protocol_error("timed out waiting for pending results to come out");
            end
            @(posedge i_clock);
            waited++;
        end
    endtask

    // Output checks first, then capture of a new request.
    always @(negedge i_clock)
    begin
        assert (o_valid === 1'b0 || o_valid === 1'b1)
        else protocol_error("o_valid is unknown");
        if (o_valid)
        begin
            assert (exp_z.size() != 0)
            else protocol_error("o_valid pulsed with no request in flight");
            assert (exp_cyc[0] == cyc)
            else value_error("result cycle", exp_cyc[0], cyc);
            assert (o_z == exp_z[0])
            else value_error("o_z", exp_z[0], o_z);
            assert (o_tag == exp_tag[0])
            else value_error("o_tag", exp_tag[0], o_tag);
            void'(exp_z.pop_front());
            void'(exp_tag.pop_front());
            void'(exp_cyc.pop_front());
            n_results++;
            // Track back-to-back output runs.
            run_len = (cyc == last_out_cyc + 1) ? run_len + 1 : 1;
            if (run_len > max_run)
            begin
                max_run = run_len;
            end
            last_out_cyc = cyc;
        end
        else if (exp_cyc.size() != 0 && exp_cyc[0] <= cyc)
        begin
            protocol_error("o_valid missing at the expected cycle");
        end
        if (i_valid === 1'b1)
        begin
            exp_z.push_back(mult_model(i_a, i_b));
            exp_tag.push_back(i_tag);
            exp_cyc.push_back(cyc + 4);
        end
    end

    initial
    begin
        int start;
        int gap;
        logic [127:0] a;
        logic [127:0] x127;
        i_rst_n   = 1'b0;
        i_valid   = 1'b0;
        i_a       = '0;
        i_b       = '0;
        i_tag     = '0;
        x127      = 128'b1 << 127;
        test_name = "reset_idle";
        repeat (16) @(posedge i_clock);
        #2;
        i_rst_n = 1'b1;
        repeat (8) drive_idle();

        // Random pairs with random gaps.
        test_name = "random";
        start = n_results;
        for (int i = 0; i < 300; i++)
        begin
            drive_pair(rand128(), rand128(), 4'($random(seed)));
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) drive_idle();
        end
        drive_idle();
        wait_drain(20);
        assert (n_results - start == 300)
        else value_error("result count", 300, n_results - start);

        // Back-to-back burst.
        test_name = "burst";
        start = n_results;
        max_run = 0;
        for (int i = 0; i < 50; i++)
        begin
            drive_pair(rand128(), rand128(), 4'(i));
        end
        drive_idle();
        wait_drain(20);
        assert (n_results - start == 50)
        else value_error("result count", 50, n_results - start);
        assert (max_run >= 50)
        else value_error("consecutive results", 50, max_run);

        // Known identities of the model itself.
        test_name = "corner";
        a = rand128();
        assert (mult_model('0, a) == '0)
        else value_error("model zero", '0, mult_model('0, a));
        assert (mult_model(128'h1, a) == a)
        else value_error("model one", a, mult_model(128'h1, a));
        drive_pair('0, a, 4'h1);
        drive_pair(a, '0, 4'h2);
        drive_pair(128'h1, a, 4'h3);
        drive_pair(a, 128'h1, 4'h4);
        // Double fold.
        drive_pair(x127, x127, 4'h5);
        drive_pair('1, '1, 4'h6);
        drive_idle();
        wait_drain(20);
        repeat (8) drive_idle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
